/* bench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic report_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
    $display("ERROR %0d ns %s: got %h, expected %h", $time, sig, got, exp);
    errors++;
endtask

task automatic note_failure(string what);
    $display("%0d ns: %s", $time, what);
    errors++;
endtask

task automatic close_test(string name, int err_start);
    tests_run++;
    if (errors == err_start)
        $display("Test %s: passed", name);
    else
        $display("Test %s: %0d errors", name, errors - err_start);
endtask

////////////////////
// One processor access, checked against the region rules
task automatic run_access(input mem_router_pkg::mem_op_e op, input logic [31:0] a,
                          input logic [31:0] wd, input logic [3:0] ws);
    logic                    to_console;
    logic                    to_cache;
    logic                    ready_seen;
    int                      waited;
    int                      count_before;
    mem_router_pkg::mem_op_e cache_exp;
    to_console   = (a == CONSOLE_ADDR) && (op == mem_router_pkg::MEM_WRITE);
    to_cache     = (a != CONSOLE_ADDR) && (a < PERIPH_BASE);
    cache_exp    = to_cache ? op : mem_router_pkg::MEM_NONE;
    count_before = seen_count;
    waited       = 0;
    ready_seen   = 1'b0;
    @(posedge CLK);
    proc_op    <= op;
    proc_addr  <= a;
    proc_wdata <= wd;
    proc_wstrb <= ws;
    // Request held until accepted
    while (!ready_seen && waited < PHASE_LIMIT)
    begin
        @(negedge CLK);
        if (cache_op !== cache_exp)
            report_mismatch("cache_op", 32'(cache_op), 32'(cache_exp));
        if (console_wr_enb !== 1'b0)
            report_mismatch("console_wr_enb", 32'(console_wr_enb), 32'd0);
        if (periph_req !== 1'b0)
            report_mismatch("periph_req", 32'(periph_req), 32'd0);
        if (proc_ready)
            ready_seen = 1'b1;
        else
            waited++;
    end
    if (!ready_seen)
        note_failure($sformatf("access to %h was never accepted", a));
    if (to_cache && waited != cache_delay)
        report_mismatch("proc_ready low cycles", waited, cache_delay);
    if (to_cache && op == mem_router_pkg::MEM_READ && proc_rdata !== ~a)
        report_mismatch("proc_rdata", proc_rdata, ~a);
    if (to_cache && cache_addr !== a)
        report_mismatch("cache_addr", cache_addr, a);
    if (to_cache && op == mem_router_pkg::MEM_WRITE && cache_wdata !== wd)
        report_mismatch("cache_wdata", cache_wdata, wd);
    if (to_cache && op == mem_router_pkg::MEM_WRITE && cache_wstrb !== ws)
        report_mismatch("cache_wstrb", 32'(cache_wstrb), 32'(ws));
    @(posedge CLK);
    proc_op <= mem_router_pkg::MEM_NONE;
    if (to_console)
    begin
        @(negedge CLK);
        if (console_wr_enb !== 1'b1)
            report_mismatch("console_wr_enb", 32'(console_wr_enb), 32'd1);
        if (console_wr_data !== wd)
            report_mismatch("console_wr_data", console_wr_data, wd);
        if (periph_req !== 1'b0)
            report_mismatch("periph_req", 32'(periph_req), 32'd0);
        @(negedge CLK);
        if (console_wr_enb !== 1'b0)
            report_mismatch("console_wr_enb", 32'(console_wr_enb), 32'd0);
    end
    else if (!to_cache)
    begin
        waited     = 0;
        ready_seen = 1'b0;
        @(negedge CLK);
        if (proc_ready !== 1'b0)
            report_mismatch("proc_ready", 32'(proc_ready), 32'd0);
        while (!ready_seen && waited < PHASE_LIMIT)
        begin
            @(negedge CLK);
            if (cache_op !== mem_router_pkg::MEM_NONE)
                report_mismatch("cache_op", 32'(cache_op), 32'(mem_router_pkg::MEM_NONE));
            if (proc_ready)
                ready_seen = 1'b1;
            else
                waited++;
        end
        if (!ready_seen)
            note_failure($sformatf("peripheral access to %h never completed", a));
        if (periph_req !== 1'b0 || periph_ack !== 1'b0)
            note_failure($sformatf("handshake for %h still open at completion", a));
        if (seen_count != count_before + 1)
            report_mismatch("peripheral transfers", seen_count - count_before, 1);
        if (seen_addr !== a)
            report_mismatch("periph_addr", seen_addr, a);
        if (seen_write !== (op == mem_router_pkg::MEM_WRITE))
            report_mismatch("periph_write", 32'(seen_write), 32'(op == mem_router_pkg::MEM_WRITE));
        if (op == mem_router_pkg::MEM_WRITE && seen_wdata !== wd)
            report_mismatch("periph_wdata", seen_wdata, wd);
        if (op == mem_router_pkg::MEM_WRITE && seen_wstrb !== ws)
            report_mismatch("periph_wstrb", 32'(seen_wstrb), 32'(ws));
        if (op == mem_router_pkg::MEM_READ && proc_rdata !== a + 32'h55)
            report_mismatch("proc_rdata", proc_rdata, a + 32'h55);
    end
    else
    begin
        // No console pulse and no peripheral stall after a cache access
        @(negedge CLK);
        if (console_wr_enb !== 1'b0)
            report_mismatch("console_wr_enb", 32'(console_wr_enb), 32'd0);
        if (proc_ready !== 1'b1)
            report_mismatch("proc_ready", 32'(proc_ready), 32'd1);
    end
endtask

////////////////////
// Directed tests
task automatic test_reset();
    int err_start;
    err_start = errors;
    @(negedge CLK);
    if (console_wr_enb !== 1'b0)
        report_mismatch("console_wr_enb", 32'(console_wr_enb), 32'd0);
    if (periph_req !== 1'b0)
        report_mismatch("periph_req", 32'(periph_req), 32'd0);
    if (proc_ready !== cache_ready)
        report_mismatch("proc_ready", 32'(proc_ready), 32'(cache_ready));
    close_test("reset state", err_start);
endtask

task automatic test_cache();
    int err_start;
    err_start   = errors;
    cache_delay = 0;
    run_access(mem_router_pkg::MEM_READ, 32'h0000_1000, 32'h0, 4'h0);
    cache_delay = 2;
    run_access(mem_router_pkg::MEM_WRITE, 32'h0000_2004, 32'h1234_5678, 4'b1111);
    cache_delay = 3;
    run_access(mem_router_pkg::MEM_READ, 32'h0fff_fffc, 32'h0, 4'h0);
    cache_delay = 1;
    run_access(mem_router_pkg::MEM_WRITE, 32'h0000_0040, 32'hdead_beef, 4'b0110);
    cache_delay = 0;
    close_test("cache forwarding", err_start);
endtask

task automatic test_console();
    int err_start;
    err_start = errors;
    run_access(mem_router_pkg::MEM_WRITE, CONSOLE_ADDR, 32'h0000_0041, 4'b0001);
    run_access(mem_router_pkg::MEM_WRITE, CONSOLE_ADDR, 32'h0000_000a, 4'b0001);
    close_test("console write", err_start);
endtask

task automatic test_periph_write();
    int err_start;
    err_start = errors;
    run_access(mem_router_pkg::MEM_WRITE, 32'h1000_0010, 32'hcafe_f00d, 4'b1111);
    run_access(mem_router_pkg::MEM_WRITE, 32'he000_1000, 32'h0000_a5a5, 4'b0011);
    close_test("peripheral write", err_start);
endtask

task automatic test_periph_read();
    int err_start;
    err_start = errors;
    run_access(mem_router_pkg::MEM_READ, 32'h2000_0040, 32'h0, 4'h0);
    run_access(mem_router_pkg::MEM_READ, 32'hf000_0000, 32'h0, 4'h0);
    // Console address read goes to the peripheral
    run_access(mem_router_pkg::MEM_READ, CONSOLE_ADDR, 32'h0, 4'h0);
    close_test("peripheral read", err_start);
endtask

task automatic test_mixed();
    int                      err_start;
    int                      i;
    int                      region;
    logic [31:0]             a;
    mem_router_pkg::mem_op_e op;
    err_start = errors;
    for (i = 0; i < 20; i++)
    begin
        region      = $urandom_range(2, 0);
        op          = ($urandom_range(1, 0) == 0) ? mem_router_pkg::MEM_READ
                                                  : mem_router_pkg::MEM_WRITE;
        cache_delay = $urandom_range(3, 0);
        a           = $urandom & 32'hffff_fffc;
        if (region == 0)
            a = a % PERIPH_BASE;
        else if (region == 1)
            a = CONSOLE_ADDR;
        else if (a < PERIPH_BASE)
            a = a + PERIPH_BASE;
        run_access(op, a, $urandom, 4'($urandom));
    end
    cache_delay = 0;
    close_test("mixed stream", err_start);
endtask

`endif

/* bench/tb_mem_router.sv */
module tb_mem_router;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] PERIPH_BASE  = mem_router_pkg::DEFAULT_PERIPH_BASE;
    localparam logic [31:0] CONSOLE_ADDR = mem_router_pkg::DEFAULT_CONSOLE_ADDR;

    // Worst case per access in cycles, issue edge to completion
    localparam int CACHE_CYCLES   = 6;
    localparam int CONSOLE_CYCLES = 4;
    localparam int PERIPH_CYCLES  = 16;
    localparam int WORST_CYCLES   = 3 + 1 + 4 * CACHE_CYCLES + 2 * CONSOLE_CYCLES
                                    + 5 * PERIPH_CYCLES + 20 * PERIPH_CYCLES;
    localparam int PHASE_LIMIT    = 20;

    logic                    CLK = 1'b0;
    logic                    RSTN = 1'b0;
    mem_router_pkg::mem_op_e proc_op = mem_router_pkg::MEM_NONE;
    logic [31:0]             proc_addr = '0;
    logic [31:0]             proc_wdata = '0;
    logic [3:0]              proc_wstrb = '0;
    logic [31:0]             proc_rdata;
    logic                    proc_ready;
    mem_router_pkg::mem_op_e cache_op;
    logic [31:0]             cache_addr;
    logic [31:0]             cache_wdata;
    logic [3:0]              cache_wstrb;
    logic [31:0]             cache_rdata;
    logic                    cache_ready;
    logic                    console_wr_enb;
    logic [31:0]             console_wr_data;
    logic                    periph_req;
    logic [31:0]             periph_addr;
    logic                    periph_write;
    logic [31:0]             periph_wdata;
    logic [3:0]              periph_wstrb;
    logic                    periph_ack = 1'b0;
    logic [31:0]             periph_rdata = '0;

    int          errors = 0;
    int          tests_run = 0;
    int          cache_delay = 0;
    int          cache_wait = 0;
    int          ack_delay = 0;
    int          ack_wait = 0;
    logic        req_prev = 1'b0;
    int          order_errors = 0;
    int          seen_count = 0;
    logic        seen_write = 1'b0;
    logic [31:0] seen_addr = '0;
    logic [31:0] seen_wdata = '0;
    logic [3:0]  seen_wstrb = '0;

    mem_router_top i_mem_router_top (.*);

    initial
    begin
        forever #50 CLK = ~CLK;
    end

    ////////////////////
    // Cache model
    assign cache_ready = (cache_op == mem_router_pkg::MEM_NONE) || (cache_wait >= cache_delay);
    assign cache_rdata = ~cache_addr;

    always @(posedge CLK)
    begin
        if (!RSTN || cache_ready)
            cache_wait <= 0;
        else
            cache_wait <= cache_wait + 1;
    end

    ////////////////////
    // Four-phase peripheral responder
    always @(posedge CLK)
    begin
        if (!RSTN)
        begin
            periph_ack <= 1'b0;
            ack_wait   <= 0;
            ack_delay  <= $urandom_range(5, 0);
            req_prev   <= 1'b0;
        end
        else
        begin
            req_prev <= periph_req;
            if (periph_req && !req_prev && periph_ack)
            begin
                $display("%0d ns: periph_req rose while periph_ack was still high", $time);
                order_errors <= order_errors + 1;
            end
            if (!periph_req && req_prev && !periph_ack)
            begin
                $display("%0d ns: periph_req fell before periph_ack was raised", $time);
                order_errors <= order_errors + 1;
            end
            if (periph_req && !periph_ack)
            begin
                if (ack_wait >= ack_delay)
                begin
                    periph_ack   <= 1'b1;
                    periph_rdata <= periph_addr + 32'h55;
                    seen_count   <= seen_count + 1;
                    seen_write   <= periph_write;
                    seen_addr    <= periph_addr;
                    seen_wdata   <= periph_wdata;
                    seen_wstrb   <= periph_wstrb;
                    ack_wait     <= 0;
                    ack_delay    <= $urandom_range(5, 0);
                end
                else
                    ack_wait <= ack_wait + 1;
            end
            else if (periph_ack && !periph_req)
                periph_ack <= 1'b0;
        end
    end

    `include "tb_tasks.svh"

    ////////////////////
    // Watchdog
    initial
    begin
        repeat (WORST_CYCLES * 3 / 2) @(posedge CLK);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WORST_CYCLES * 3 / 2);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h6e20));
        repeat (3) @(posedge CLK);
        RSTN <= 1'b1;
        test_reset();
        test_cache();
        test_console();
        test_periph_write();
        test_periph_read();
        test_mixed();
        errors = errors + order_errors;
        $display("Tests run: %0d, failed checks: %0d", tests_run, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* logic/data_port_router.sv */
module data_port_router
#(
    parameter logic [mem_router_pkg::ADDR_WIDTH-1:0] PERIPH_BASE =
        mem_router_pkg::DEFAULT_PERIPH_BASE,
    parameter logic [mem_router_pkg::ADDR_WIDTH-1:0] CONSOLE_ADDR =
        mem_router_pkg::DEFAULT_CONSOLE_ADDR
)
(
    input  logic                                  CLK,
    input  logic                                  RSTN,

    // Processor data port
    input  mem_router_pkg::mem_op_e               proc_op,
    input  logic [mem_router_pkg::ADDR_WIDTH-1:0] proc_addr,
    input  logic [mem_router_pkg::DATA_WIDTH-1:0] proc_wdata,
    input  logic [mem_router_pkg::STRB_WIDTH-1:0] proc_wstrb,
    output logic [mem_router_pkg::DATA_WIDTH-1:0] proc_rdata,
    output logic                                  proc_ready,

    // Data cache
    output mem_router_pkg::mem_op_e               cache_op,
    input  logic [mem_router_pkg::DATA_WIDTH-1:0] cache_rdata,
    input  logic                                  cache_ready,

    // Console write-out
    output logic                                  console_wr_enb,
    output logic [mem_router_pkg::DATA_WIDTH-1:0] console_wr_data,

    // Peripheral bridge
    output logic                                  start,
    output logic [mem_router_pkg::ADDR_WIDTH-1:0] addr,
    output logic                                  write,
    output logic [mem_router_pkg::DATA_WIDTH-1:0] wdata,
    output logic [mem_router_pkg::STRB_WIDTH-1:0] wstrb,
    input  logic                                  busy,
    input  logic                                  done,
    input  logic [mem_router_pkg::DATA_WIDTH-1:0] rdata
);

    logic hit_console;
    logic hit_periph;
    logic hit_cache;
    logic accept;
    logic console_launch;
    logic periph_launch;

    // Peripheral access outstanding toward the processor
    logic pend;
    // Done seen while the cache held the port
    logic rsp_hold;
    logic finish;
    logic stall;

    ////////////////////
    // Address decode
    assign hit_console = (proc_addr == CONSOLE_ADDR);
    assign hit_periph  = !hit_console && (proc_addr >= PERIPH_BASE);
    assign hit_cache   = !hit_console && !hit_periph;

    assign accept = proc_ready && (proc_op != mem_router_pkg::MEM_NONE);

    assign console_launch = accept && hit_console && (proc_op == mem_router_pkg::MEM_WRITE);

    // Console reads go out as ordinary peripheral reads
    assign periph_launch = accept && (hit_periph ||
                           (hit_console && proc_op == mem_router_pkg::MEM_READ));

    ////////////////////
    // Stall and data return
    assign finish = done || rsp_hold;
    assign stall  = busy || (pend && !finish);

    assign proc_ready = cache_ready && !stall;
    assign proc_rdata = (pend && finish) ? rdata : cache_rdata;

    // Cache sees nothing while a peripheral access holds the port
    assign cache_op = (hit_cache && !stall) ? proc_op : mem_router_pkg::MEM_NONE;

    always_ff @(posedge CLK)
    begin
        if (!RSTN)
        begin
            start          <= 1'b0;
            console_wr_enb <= 1'b0;
            pend           <= 1'b0;
            rsp_hold       <= 1'b0;
        end
        else
        begin
            start          <= periph_launch;
            console_wr_enb <= console_launch;

            if (periph_launch)
                pend <= 1'b1;
            else if (finish && cache_ready)
                pend <= 1'b0;

            rsp_hold <= finish && pend && !cache_ready;
        end
    end

    // Request payload
    always_ff @(posedge CLK)
    begin
        if (console_launch)
            console_wr_data <= proc_wdata;

        if (periph_launch)
        begin
            addr  <= proc_addr;
            write <= (proc_op == mem_router_pkg::MEM_WRITE);
            wdata <= proc_wdata;
            wstrb <= proc_wstrb;
        end
    end

    ////////////////////
    // Checks
    // One accepted access never lands in two regions
    a_start_console_excl: assert property (
        @(posedge CLK) disable iff (!RSTN)
        !(start && console_wr_enb)
    );

    // The stall must keep a second launch away from a busy bridge
    a_start_not_busy: assert property (
        @(posedge CLK) disable iff (!RSTN)
        start |-> !busy
    );

endmodule

/* logic/mem_router_pkg.sv */
package mem_router_pkg;

    ////////////////////
    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    ////////////////////
    // Operation on the processor and cache ports
    typedef enum logic [1:0]
    {
        MEM_NONE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_op_e;

    ////////////////////
    // Default memory map
    // Everything from here up leaves the cache
    localparam logic [ADDR_WIDTH-1:0] DEFAULT_PERIPH_BASE = 32'h1000_0000;

    // Exit FIFO, decoded ahead of the peripheral range
    localparam logic [ADDR_WIDTH-1:0] DEFAULT_CONSOLE_ADDR = 32'he000_1030;

endpackage

/* logic/mem_router_top.sv */
module mem_router_top
#(
    parameter logic [mem_router_pkg::ADDR_WIDTH-1:0] PERIPH_BASE =
        mem_router_pkg::DEFAULT_PERIPH_BASE,
    parameter logic [mem_router_pkg::ADDR_WIDTH-1:0] CONSOLE_ADDR =
        mem_router_pkg::DEFAULT_CONSOLE_ADDR
)
(
    input  logic                                  CLK,
    input  logic                                  RSTN,

    // Processor data port
    input  mem_router_pkg::mem_op_e               proc_op,
    input  logic [mem_router_pkg::ADDR_WIDTH-1:0] proc_addr,
    input  logic [mem_router_pkg::DATA_WIDTH-1:0] proc_wdata,
    input  logic [mem_router_pkg::STRB_WIDTH-1:0] proc_wstrb,
    output logic [mem_router_pkg::DATA_WIDTH-1:0] proc_rdata,
    output logic                                  proc_ready,

    // Data cache
    output mem_router_pkg::mem_op_e               cache_op,
    output logic [mem_router_pkg::ADDR_WIDTH-1:0] cache_addr,
    output logic [mem_router_pkg::DATA_WIDTH-1:0] cache_wdata,
    output logic [mem_router_pkg::STRB_WIDTH-1:0] cache_wstrb,
    input  logic [mem_router_pkg::DATA_WIDTH-1:0] cache_rdata,
    input  logic                                  cache_ready,

    // Console write-out
    output logic                                  console_wr_enb,
    output logic [mem_router_pkg::DATA_WIDTH-1:0] console_wr_data,

    // Peripheral
    output logic                                  periph_req,
    output logic [mem_router_pkg::ADDR_WIDTH-1:0] periph_addr,
    output logic                                  periph_write,
    output logic [mem_router_pkg::DATA_WIDTH-1:0] periph_wdata,
    output logic [mem_router_pkg::STRB_WIDTH-1:0] periph_wstrb,
    input  logic                                  periph_ack,
    input  logic [mem_router_pkg::DATA_WIDTH-1:0] periph_rdata
);

    logic                                  start;
    logic                                  busy;
    logic                                  done;
    logic [mem_router_pkg::ADDR_WIDTH-1:0] br_addr;
    logic                                  br_write;
    logic [mem_router_pkg::DATA_WIDTH-1:0] br_wdata;
    logic [mem_router_pkg::STRB_WIDTH-1:0] br_wstrb;
    logic [mem_router_pkg::DATA_WIDTH-1:0] br_rdata;

    // Cache takes address and write data straight from the processor
    assign cache_addr  = proc_addr;
    assign cache_wdata = proc_wdata;
    assign cache_wstrb = proc_wstrb;

    data_port_router
    #(
        .PERIPH_BASE     (PERIPH_BASE),
        .CONSOLE_ADDR    (CONSOLE_ADDR)
    )
    i_data_port_router
    (
        .CLK             (CLK),
        .RSTN            (RSTN),
        .proc_op         (proc_op),
        .proc_addr       (proc_addr),
        .proc_wdata      (proc_wdata),
        .proc_wstrb      (proc_wstrb),
        .proc_rdata      (proc_rdata),
        .proc_ready      (proc_ready),
        .cache_op        (cache_op),
        .cache_rdata     (cache_rdata),
        .cache_ready     (cache_ready),
        .console_wr_enb  (console_wr_enb),
        .console_wr_data (console_wr_data),
        .start           (start),
        .addr            (br_addr),
        .write           (br_write),
        .wdata           (br_wdata),
        .wstrb           (br_wstrb),
        .busy            (busy),
        .done            (done),
        .rdata           (br_rdata)
    );

    periph_bridge i_periph_bridge
    (
        .CLK             (CLK),
        .RSTN            (RSTN),
        .start           (start),
        .addr            (br_addr),
        .write           (br_write),
        .wdata           (br_wdata),
        .wstrb           (br_wstrb),
        .busy            (busy),
        .done            (done),
        .rdata           (br_rdata),
        .periph_req      (periph_req),
        .periph_addr     (periph_addr),
        .periph_write    (periph_write),
        .periph_wdata    (periph_wdata),
        .periph_wstrb    (periph_wstrb),
        .periph_ack      (periph_ack),
        .periph_rdata    (periph_rdata)
    );

endmodule

/* logic/periph_bridge.sv */
module periph_bridge
(
    input  logic                                  CLK,
    input  logic                                  RSTN,

    // From the router
    input  logic                                  start,
    input  logic [mem_router_pkg::ADDR_WIDTH-1:0] addr,
    input  logic                                  write,
    input  logic [mem_router_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [mem_router_pkg::STRB_WIDTH-1:0] wstrb,
    output logic                                  busy,
    output logic                                  done,
    output logic [mem_router_pkg::DATA_WIDTH-1:0] rdata,

    // Four-phase peripheral port
    output logic                                  periph_req,
    output logic [mem_router_pkg::ADDR_WIDTH-1:0] periph_addr,
    output logic                                  periph_write,
    output logic [mem_router_pkg::DATA_WIDTH-1:0] periph_wdata,
    output logic [mem_router_pkg::STRB_WIDTH-1:0] periph_wstrb,
    input  logic                                  periph_ack,
    input  logic [mem_router_pkg::DATA_WIDTH-1:0] periph_rdata
);

    typedef enum logic [1:0]
    {
        ST_IDLE    = 2'd0,
        ST_REQ     = 2'd1,
        ST_RELEASE = 2'd2,
        ST_DONE    = 2'd3
    } state_e;

    state_e state;
    state_e state_nxt;

    ////////////////////
    // Handshake FSM
    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                if (start)
                    state_nxt = ST_REQ;
            end
            ST_REQ:
            begin
                if (periph_ack)
                    state_nxt = ST_RELEASE;
            end
            // Wait for the peripheral to let go of ack
            ST_RELEASE:
            begin
                if (!periph_ack)
                    state_nxt = ST_DONE;
            end
            ST_DONE:
            begin
                state_nxt = ST_IDLE;
            end
            default:
            begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!RSTN)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    assign periph_req = (state == ST_REQ);
    assign busy       = (state == ST_REQ) || (state == ST_RELEASE);
    assign done       = (state == ST_DONE);

    // Fields held from start until the next access
    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && start)
        begin
            periph_addr  <= addr;
            periph_write <= write;
            periph_wdata <= wdata;
            periph_wstrb <= wstrb;
        end

        if (state == ST_REQ && periph_ack)
            rdata <= periph_rdata;
    end

    ////////////////////
    // Checks
    a_req_held_until_ack: assert property (
        @(posedge CLK) disable iff (!RSTN)
        periph_req && !periph_ack |=> periph_req
    );

    a_fields_stable: assert property (
        @(posedge CLK) disable iff (!RSTN)
        periph_req |=> !periph_req ||
            $stable({periph_addr, periph_write, periph_wdata, periph_wstrb})
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory router testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_mem_router

./obj_dir/Vtb_mem_router | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

/* tb.f */
logic/mem_router_pkg.sv
logic/data_port_router.sv
logic/periph_bridge.sv
logic/mem_router_top.sv
+incdir+bench
bench/tb_mem_router.sv
